// ==== Bender.yml ====
package:
  name: e31x_board_glue

sources:
  - include_dirs:
      - .
    files:
      - e31x_glue_pkg.sv
      - ref_status_if.sv
      - e31x_ref_sync.sv
      - e31x_button_irq.sv
      - e31x_fe_switch.sv
      - e31x_board_ctrl.sv
      - e31x_board_glue.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_e31x_board_glue.sv

// ==== e31x_board_ctrl.sv ====
/* Daughterboard control and status registers, interrupt vector packing and
   the codec reset pin. Register port is plain strobe, address and data. */
`timescale 1ns/1ps
`include "e31x_glue_config.svh"

module e31x_board_ctrl (
  input  logic                        bus_clk,
  input  logic                        bus_rst,
  input  logic                        reg_wr_stb,
  input  logic                        reg_addr,
  input  logic [`E31X_REG_DWIDTH-1:0] reg_wdata,
  input  logic                        press_irq,
  input  logic                        release_irq,
  ref_status_if.dst                   status,
  output logic [`E31X_REG_DWIDTH-1:0] reg_rdata,
  output logic [`E31X_IRQ_WIDTH-1:0]  irq_f2p,
  output logic                        mimo,
  output logic                        codec_reset_n,
  output logic                        pps_gpio
);

  // MIMO and codec reset control bits
  logic [1:0]                  ctrl_reg;
  logic [`E31X_REG_DWIDTH-1:0] status_word;

  //////////////////////////////////////////////////
  // Control register
  //////////////////////////////////////////////////
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      ctrl_reg <= 2'b00;
    end else if (reg_wr_stb && (reg_addr == 1'(e31x_glue_pkg::reg_addr_ctrl))) begin
      ctrl_reg <= reg_wdata[1:0];
    end
  end

  assign mimo = ctrl_reg[e31x_glue_pkg::ctrl_bit_mimo];

  // Codec pin is active low
  // Held in reset by bus reset or by software
  assign codec_reset_n = !(bus_rst || ctrl_reg[e31x_glue_pkg::ctrl_bit_codec_rst]);

  //////////////////////////////////////////////////
  // Status word and readback
  //////////////////////////////////////////////////
  always_comb begin
    status_word = '0;
    status_word[e31x_glue_pkg::status_tcxo_lsb +: 4]      = status.tcxo_status;
    status_word[e31x_glue_pkg::status_tx_lock_bit]        = status.tx_lock;
    status_word[e31x_glue_pkg::status_rx_lock_bit]        = status.rx_lock;
  end

  // Address decode, status address is read-only
  assign reg_rdata = (reg_addr == 1'(e31x_glue_pkg::reg_addr_status)) ?
                     status_word : {{(`E31X_REG_DWIDTH-2){1'b0}}, ctrl_reg};

  // PPS straight out to the processor GPIO
  assign pps_gpio = status.pps_sync;

  //////////////////////////////////////////////////
  // Interrupt vector
  //////////////////////////////////////////////////
  always_comb begin
    irq_f2p = '0;
    irq_f2p[e31x_glue_pkg::irq_bit_press]   = press_irq;
    irq_f2p[e31x_glue_pkg::irq_bit_release] = release_irq;
  end

  // Unowned vector lines, bit 3 included, stay quiet
  a_irq_unused_zero: assert property (
    @(posedge bus_clk) disable iff (bus_rst)
    $countones(irq_f2p) == $countones({press_irq, release_irq})
  ) else $error("interrupt raised outside press and release bits");

endmodule

// ==== e31x_board_glue.f ====
+incdir+.
e31x_glue_pkg.sv
ref_status_if.sv
e31x_ref_sync.sv
e31x_button_irq.sv
e31x_fe_switch.sv
e31x_board_ctrl.sv
e31x_board_glue.sv
tb_e31x_board_glue.sv

// ==== e31x_board_glue.sv ====
/* Top level of the bus_clk board glue with plain ports. Connects the status
   synchroniser, button interrupts, antenna switch decode and control block. */
`timescale 1ns/1ps
`include "e31x_glue_config.svh"

module e31x_board_glue (
  input  logic                           bus_clk,
  input  logic                           bus_rst,
  input  logic                           onswitch_n,
  input  logic                           gps_pps,
  input  logic [3:0]                     ref_status_in,
  input  logic [1:0]                     pll_lock_in,
  input  logic [`E31X_FE_GPIO_WIDTH-1:0] fe_gpio_path1,
  input  logic [`E31X_FE_GPIO_WIDTH-1:0] fe_gpio_path2,
  input  logic                           reg_wr_stb,
  input  logic                           reg_addr,
  input  logic [`E31X_REG_DWIDTH-1:0]    reg_wdata,
  output logic [`E31X_REG_DWIDTH-1:0]    reg_rdata,
  output logic [`E31X_IRQ_WIDTH-1:0]     irq_f2p,
  output logic                           pps_gpio,
  output logic                           mimo,
  output logic                           codec_reset_n,
  output logic                           vctx1_v1,
  output logic                           vctx1_v2,
  output logic                           vcrx1_v1,
  output logic                           vcrx1_v2,
  output logic                           vctx2_v1,
  output logic                           vctx2_v2,
  output logic                           vcrx2_v1,
  output logic                           vcrx2_v2,
  output logic [2:0]                     tx_bandsel
);

  // Stretched button interrupts
  logic press_irq;
  logic release_irq;

  // Synchronised status bundle
  ref_status_if status_bus ();

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////
  e31x_ref_sync ref_sync0 (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .ref_status_in (ref_status_in),
    .pll_lock_in   (pll_lock_in),
    .gps_pps       (gps_pps),
    .status        (status_bus.src)
  );

  e31x_button_irq button_irq0 (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .onswitch_n  (onswitch_n),
    .press_irq   (press_irq),
    .release_irq (release_irq)
  );

  // No clock, table decode only
  e31x_fe_switch fe_switch0 (
    .fe_gpio_path1 (fe_gpio_path1),
    .fe_gpio_path2 (fe_gpio_path2),
    .vctx1_v1      (vctx1_v1),
    .vctx1_v2      (vctx1_v2),
    .vcrx1_v1      (vcrx1_v1),
    .vcrx1_v2      (vcrx1_v2),
    .vctx2_v1      (vctx2_v1),
    .vctx2_v2      (vctx2_v2),
    .vcrx2_v1      (vcrx2_v1),
    .vcrx2_v2      (vcrx2_v2),
    .tx_bandsel    (tx_bandsel)
  );

  e31x_board_ctrl board_ctrl0 (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .reg_wr_stb    (reg_wr_stb),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_wdata),
    .press_irq     (press_irq),
    .release_irq   (release_irq),
    .status        (status_bus.dst),
    .reg_rdata     (reg_rdata),
    .irq_f2p       (irq_f2p),
    .mimo          (mimo),
    .codec_reset_n (codec_reset_n),
    .pps_gpio      (pps_gpio)
  );

endmodule

// ==== e31x_button_irq.sv ====
/* Power-button edge detection with stretched press and release pulses.
   The outputs feed the interrupt vector in the control block. */
`timescale 1ns/1ps
`include "e31x_glue_config.svh"

module e31x_button_irq (
  input  logic bus_clk,
  input  logic bus_rst,
  // Debounced button, low while pressed
  input  logic onswitch_n,
  output logic press_irq,
  output logic release_irq
);

  // Last two samples, newest in bit 0
  logic [1:0] btn_hist;
  logic       press_det;
  logic       release_det;
  logic [`E31X_STRETCH_LEN-1:0] press_sr;
  logic [`E31X_STRETCH_LEN-1:0] release_sr;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      btn_hist <= 2'b00;
    end else begin
      btn_hist <= {btn_hist[0], onswitch_n};
    end
  end

  // Edge needs two stable samples before the change
  // Return edge of a single-sample glitch never qualifies
  assign press_det   = !onswitch_n && btn_hist[0] && btn_hist[1];
  assign release_det = onswitch_n && !btn_hist[0] && !btn_hist[1];

  //////////////////////////////////////////////////
  // Pulse stretch so the processor cannot miss it
  //////////////////////////////////////////////////
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      press_sr   <= '0;
      release_sr <= '0;
    end else begin
      press_sr   <= {press_sr[`E31X_STRETCH_LEN-2:0], press_det};
      release_sr <= {release_sr[`E31X_STRETCH_LEN-2:0], release_det};
    end
  end

  // Repeated detections extend the pulse
  assign press_irq   = |press_sr;
  assign release_irq = |release_sr;

  // No detection on the sample right after another one
  // So one edge starts at most one of the two stretches
  a_single_stretch: assert property (
    @(posedge bus_clk) disable iff (bus_rst)
    (press_det || release_det) |=> !(press_det || release_det)
  ) else $error("button edges detected on adjacent samples");

endmodule

// ==== e31x_fe_switch.sv ====
/* Antenna switch decode for both RF paths and the shared TX band select.
   Purely combinational from the two front-end GPIO words. */
`timescale 1ns/1ps
`include "e31x_glue_config.svh"

module e31x_fe_switch (
  input  logic [`E31X_FE_GPIO_WIDTH-1:0] fe_gpio_path1,
  input  logic [`E31X_FE_GPIO_WIDTH-1:0] fe_gpio_path2,
  output logic                           vctx1_v1,
  output logic                           vctx1_v2,
  output logic                           vcrx1_v1,
  output logic                           vcrx1_v2,
  output logic                           vctx2_v1,
  output logic                           vctx2_v2,
  output logic                           vcrx2_v1,
  output logic                           vcrx2_v2,
  output logic [2:0]                     tx_bandsel
);

  //////////////////////////////////////////////////
  // Decode tables
  //////////////////////////////////////////////////
  // TX/RX port goes to TX only with both bits set
  function automatic logic [1:0] tx_pair_sel(input logic txrx_v1, input logic txrx_v2);
    tx_pair_sel = (txrx_v1 && txrx_v2) ? 2'b10 : 2'b01;
  endfunction

  // RX port selected only on pattern V1 set, V2 clear
  function automatic logic [1:0] rx_pair_sel(input logic rx_v1, input logic rx_v2);
    rx_pair_sel = (rx_v1 && !rx_v2) ? 2'b10 : 2'b01;
  endfunction

  // Each path decodes only its own bits
  always_comb begin
    {vctx1_v1, vctx1_v2} = tx_pair_sel(fe_gpio_path1[e31x_glue_pkg::fe_txrx_v1_bit],
                                       fe_gpio_path1[e31x_glue_pkg::fe_txrx_v2_bit]);
    {vcrx1_v1, vcrx1_v2} = rx_pair_sel(fe_gpio_path1[e31x_glue_pkg::fe_rx_v1_bit],
                                       fe_gpio_path1[e31x_glue_pkg::fe_rx_v2_bit]);
    {vctx2_v1, vctx2_v2} = tx_pair_sel(fe_gpio_path2[e31x_glue_pkg::fe_txrx_v1_bit],
                                       fe_gpio_path2[e31x_glue_pkg::fe_txrx_v2_bit]);
    {vcrx2_v1, vcrx2_v2} = rx_pair_sel(fe_gpio_path2[e31x_glue_pkg::fe_rx_v1_bit],
                                       fe_gpio_path2[e31x_glue_pkg::fe_rx_v2_bit]);
  end

  //////////////////////////////////////////////////
  // Band select
  //////////////////////////////////////////////////
  // Both paths share one TX filter bank
  // OR lets either path set it alone
  assign tx_bandsel = fe_gpio_path1[e31x_glue_pkg::fe_tx_bandsel_lsb +: 3] |
                      fe_gpio_path2[e31x_glue_pkg::fe_tx_bandsel_lsb +: 3];

  // Switch pins are never both driven or both open
  always_comb begin
    a_pairs_onehot: assert #0 (
      $onehot({vctx1_v1, vctx1_v2}) && $onehot({vcrx1_v1, vcrx1_v2}) &&
      $onehot({vctx2_v1, vctx2_v2}) && $onehot({vcrx2_v1, vcrx2_v2})
    ) else $error("antenna switch pair not one-hot");
  end

endmodule

// ==== e31x_glue_config.svh ====
/* Fixed board widths, synchroniser depths and interrupt stretch length.
   Included by every glue module and by the testbench. */
`ifndef E31X_GLUE_CONFIG_SVH
`define E31X_GLUE_CONFIG_SVH

// Register port data width
`define E31X_REG_DWIDTH 32

// One front-end GPIO word per RF path
`define E31X_FE_GPIO_WIDTH 16

// Fabric to processor interrupt vector
`define E31X_IRQ_WIDTH 16

// Flop stages for reference status and PLL lock bits
`define E31X_SYNC_STAGES 2

// Flop stages on the GPS PPS path
`define E31X_PPS_STAGES 3

// Button interrupt stretch, in bus_clk cycles
`define E31X_STRETCH_LEN 8

`endif

// ==== e31x_glue_pkg.sv ====
/* Register map, status and interrupt bit positions and front-end GPIO fields.
   Referenced by scoped name from the control, switch and test code. */
package e31x_glue_pkg;

  //////////////////////////////////////////////////
  // Register addresses
  //////////////////////////////////////////////////
  localparam int reg_addr_ctrl   = 0;
  localparam int reg_addr_status = 1;

  // Control register fields
  localparam int ctrl_bit_mimo      = 0;
  localparam int ctrl_bit_codec_rst = 1;

  //////////////////////////////////////////////////
  // Status word fields
  //////////////////////////////////////////////////
  // 4-bit reference field {pll lock, 10 MHz, PPS, ref locked}
  localparam int status_tcxo_lsb    = 10;
  localparam int status_tx_lock_bit = 9;
  localparam int status_rx_lock_bit = 8;

  // Interrupt vector positions
  // Bit 3 and all other lines tied to zero
  localparam int irq_bit_press   = 1;
  localparam int irq_bit_release = 2;

  //////////////////////////////////////////////////
  // Front-end GPIO word fields, same for both paths
  //////////////////////////////////////////////////
  localparam int fe_rx_v1_bit   = 15;
  localparam int fe_rx_v2_bit   = 14;
  localparam int fe_txrx_v1_bit = 13;
  localparam int fe_txrx_v2_bit = 12;

  // Low end of the 3-bit TX band field
  localparam int fe_tx_bandsel_lsb = 0;

endpackage

// ==== e31x_ref_sync.sv ====
/* Brings the asynchronous reference status, codec PLL locks and GPS PPS
   into the bus_clk domain and drives them onto the status interface. */
`timescale 1ns/1ps
`include "e31x_glue_config.svh"

module e31x_ref_sync (
  input  logic       bus_clk,
  input  logic       bus_rst,
  input  logic [3:0] ref_status_in,
  // Bit 1 TX lock, bit 0 RX lock
  input  logic [1:0] pll_lock_in,
  input  logic       gps_pps,
  ref_status_if.src  status
);

  //////////////////////////////////////////////////
  // Status and lock synchroniser
  //////////////////////////////////////////////////
  // Packed as {ref status, tx lock, rx lock}
  logic [5:0] st_sync [`E31X_SYNC_STAGES];

  // Plain flop chain, stage 0 samples the async pins
  always_ff @(posedge bus_clk) begin
    st_sync[0] <= {ref_status_in, pll_lock_in};
    for (int i = 1; i < `E31X_SYNC_STAGES; i++) begin
      st_sync[i] <= st_sync[i-1];
    end
  end

  // Last stage onto the interface
  assign status.tcxo_status = st_sync[`E31X_SYNC_STAGES-1][5:2];
  assign status.tx_lock     = st_sync[`E31X_SYNC_STAGES-1][1];
  assign status.rx_lock     = st_sync[`E31X_SYNC_STAGES-1][0];

  //////////////////////////////////////////////////
  // PPS shift
  //////////////////////////////////////////////////
  logic [`E31X_PPS_STAGES-1:0] pps_sr;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      pps_sr <= '0;
    end else begin
      pps_sr <= {pps_sr[`E31X_PPS_STAGES-2:0], gps_pps};
    end
  end

  // Oldest sample goes out to the GPIO
  assign status.pps_sync = pps_sr[`E31X_PPS_STAGES-1];

  // No PPS edge reaches the processor out of reset
  a_pps_low_in_reset: assert property (
    @(posedge bus_clk) bus_rst |=> !status.pps_sync
  ) else $error("pps_sync high after a reset cycle");

endmodule

// ==== ref_status_if.sv ====
/* Synchronised reference, lock and PPS levels from the synchroniser block
   to the control block. Plain levels, no handshake. */
`timescale 1ns/1ps

interface ref_status_if;

  // {pll lock, 10 MHz present, PPS present, ref locked}
  logic [3:0] tcxo_status;
  // Codec PLL locks
  logic       tx_lock;
  logic       rx_lock;
  // Resynchronised GPS PPS
  logic       pps_sync;

  // Synchroniser side
  modport src (output tcxo_status, output tx_lock, output rx_lock, output pps_sync);
  // Control block side
  modport dst (input tcxo_status, input tx_lock, input rx_lock, input pps_sync);

endinterface

// ==== tb_e31x_board_glue.sv ====
/* Testbench for the board glue top level. Random stimulus reaches every
   check, and concurrent assertions compare the DUT with small reference models. */
`timescale 1ns/1ps
`include "e31x_glue_config.svh"

module tb_e31x_board_glue;

  localparam int max_cycles = 4000;

  logic        bus_clk;
  logic        bus_rst;
  logic        onswitch_n;
  logic        gps_pps;
  logic [3:0]  ref_status_in;
  logic [1:0]  pll_lock_in;
  logic [15:0] fe_gpio_path1;
  logic [15:0] fe_gpio_path2;
  logic        reg_wr_stb;
  logic        reg_addr;
  logic [31:0] reg_wdata;
  logic [31:0] reg_rdata;
  logic [15:0] irq_f2p;
  logic        pps_gpio;
  logic        mimo;
  logic        codec_reset_n;
  logic        vctx1_v1;
  logic        vctx1_v2;
  logic        vcrx1_v1;
  logic        vcrx1_v2;
  logic        vctx2_v1;
  logic        vctx2_v2;
  logic        vcrx2_v1;
  logic        vcrx2_v2;
  logic [2:0]  tx_bandsel;

  int          seed;
  int          cycle = 0;

  e31x_board_glue dut0 (.*);

  initial begin
    bus_clk = 1'b0;
    forever #20 bus_clk = ~bus_clk;
  end

  ////////////////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////////////////
  // {TX pair, RX pair} of one path, V1 first
  function automatic logic [3:0] path_switch(input logic [15:0] w);
    logic [1:0] tx;
    logic [1:0] rx;
    tx = (w[e31x_glue_pkg::fe_txrx_v1_bit] && w[e31x_glue_pkg::fe_txrx_v2_bit]) ? 2'b10 : 2'b01;
    rx = (w[e31x_glue_pkg::fe_rx_v1_bit] && !w[e31x_glue_pkg::fe_rx_v2_bit]) ? 2'b10 : 2'b01;
    return {tx, rx};
  endfunction

  logic [7:0]  sw_act;
  logic [7:0]  sw_exp;
  logic [2:0]  band_exp;
  assign sw_act   = {vctx1_v1, vctx1_v2, vcrx1_v1, vcrx1_v2,
                     vctx2_v1, vctx2_v2, vcrx2_v1, vcrx2_v2};
  assign sw_exp   = {path_switch(fe_gpio_path1), path_switch(fe_gpio_path2)};
  assign band_exp = fe_gpio_path1[2:0] | fe_gpio_path2[2:0];

  // Button history and remaining stretch cycles
  logic [1:0]  btn_m;
  int          press_left;
  int          release_left;
  logic [15:0] irq_exp;
  // Input history for status and PPS, shadow control register
  logic [5:0]  st_m [`E31X_SYNC_STAGES];
  logic [`E31X_PPS_STAGES-1:0] pps_m;
  logic [1:0]  ctrl_m;
  int          settle;
  logic [31:0] status_exp;

  always @(posedge bus_clk) begin
    st_m[0] <= {ref_status_in, pll_lock_in};
    for (int i = 1; i < `E31X_SYNC_STAGES; i++) begin
      st_m[i] <= st_m[i-1];
    end
    if (bus_rst) begin
      btn_m        <= 2'b00;
      press_left   <= 0;
      release_left <= 0;
      pps_m        <= '0;
      ctrl_m       <= 2'b00;
      settle       <= 0;
    end else begin
      btn_m  <= {btn_m[0], onswitch_n};
      pps_m  <= {pps_m[`E31X_PPS_STAGES-2:0], gps_pps};
      settle <= (settle < 3) ? settle + 1 : settle;
      if (!onswitch_n && btn_m == 2'b11) press_left <= `E31X_STRETCH_LEN;
      else if (press_left > 0) press_left <= press_left - 1;
      if (onswitch_n && btn_m == 2'b00) release_left <= `E31X_STRETCH_LEN;
      else if (release_left > 0) release_left <= release_left - 1;
      if (reg_wr_stb && reg_addr == 1'(e31x_glue_pkg::reg_addr_ctrl)) ctrl_m <= reg_wdata[1:0];
    end
  end

  always_comb begin
    irq_exp = '0;
    irq_exp[e31x_glue_pkg::irq_bit_press]   = (press_left != 0);
    irq_exp[e31x_glue_pkg::irq_bit_release] = (release_left != 0);
    status_exp = '0;
    status_exp[e31x_glue_pkg::status_tcxo_lsb +: 4] = st_m[`E31X_SYNC_STAGES-1][5:2];
    status_exp[e31x_glue_pkg::status_tx_lock_bit]   = st_m[`E31X_SYNC_STAGES-1][1];
    status_exp[e31x_glue_pkg::status_rx_lock_bit]   = st_m[`E31X_SYNC_STAGES-1][0];
  end

  ////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////
  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail %s: got 0x%h, expected 0x%h", sig, got, exp);
    $display("tests failed");
    $fatal(1, "mismatch on %s", sig);
  endtask

  a_switch: assert property (@(posedge bus_clk) sw_act == sw_exp)
    else report_mismatch("vctx/vcrx pins", $sampled(sw_act), $sampled(sw_exp));
  a_band: assert property (@(posedge bus_clk) tx_bandsel == band_exp)
    else report_mismatch("tx_bandsel", $sampled(tx_bandsel), $sampled(band_exp));
  a_irq: assert property (@(posedge bus_clk) !bus_rst |-> irq_f2p == irq_exp)
    else report_mismatch("irq_f2p", $sampled(irq_f2p), $sampled(irq_exp));
  a_status: assert property (@(posedge bus_clk)
    (!bus_rst && settle >= 2 && reg_addr == 1'(e31x_glue_pkg::reg_addr_status))
      |-> reg_rdata == status_exp)
    else report_mismatch("reg_rdata status", $sampled(reg_rdata), $sampled(status_exp));
  // Also low through reset, the model resets with the DUT
  a_pps: assert property (@(posedge bus_clk) cycle > 0 |-> pps_gpio == pps_m[`E31X_PPS_STAGES-1])
    else report_mismatch("pps_gpio", $sampled(pps_gpio), $sampled(pps_m[`E31X_PPS_STAGES-1]));
  a_mimo: assert property (@(posedge bus_clk) !bus_rst |-> mimo == ctrl_m[0])
    else report_mismatch("mimo", $sampled(mimo), $sampled(ctrl_m[0]));
  // Low in reset, otherwise the inverse of the shadow codec bit
  a_codec: assert property (@(posedge bus_clk)
    codec_reset_n == (bus_rst ? 1'b0 : !ctrl_m[1]))
    else report_mismatch("codec_reset_n", $sampled(codec_reset_n),
                         $sampled(bus_rst) ? 1'b0 : !$sampled(ctrl_m[1]));
  a_ctrl_read: assert property (@(posedge bus_clk)
    (!bus_rst && reg_addr == 1'(e31x_glue_pkg::reg_addr_ctrl)) |-> reg_rdata == {30'b0, ctrl_m})
    else report_mismatch("reg_rdata ctrl", $sampled(reg_rdata), {30'b0, $sampled(ctrl_m)});

  // Run limit
  always @(posedge bus_clk) begin
    cycle <= cycle + 1;
    if (cycle == max_cycles) begin
      $display("Run did not finish within %0d cycles", max_cycles);
      $display("tests failed");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////
  task automatic hold_button(input logic level, input int cycles);
    onswitch_n <= level;
    repeat (cycles) @(posedge bus_clk);
  endtask

  initial begin
    seed          = 32'h3a0b_1abe;
    bus_rst       = 1'b1;
    onswitch_n    = 1'b1;
    gps_pps       = 1'b0;
    ref_status_in = 4'h0;
    pll_lock_in   = 2'b00;
    fe_gpio_path1 = 16'h0000;
    fe_gpio_path2 = 16'h0000;
    reg_wr_stb    = 1'b0;
    reg_addr      = 1'b0;
    reg_wdata     = 32'h0;
    repeat (5) @(posedge bus_clk);
    bus_rst <= 1'b0;

    // Switch decode and band merge
    repeat (200) begin
      @(posedge bus_clk);
      fe_gpio_path1 <= $random(seed);
      fe_gpio_path2 <= $random(seed);
    end

    // Status, PPS and register writes to both addresses
    repeat (300) begin
      @(posedge bus_clk);
      ref_status_in <= $random(seed);
      pll_lock_in   <= $random(seed);
      gps_pps       <= $random(seed);
      reg_wr_stb    <= $random(seed);
      reg_addr      <= $random(seed);
      reg_wdata     <= $random(seed);
    end

    // Second reset with PPS still toggling
    @(posedge bus_clk);
    reg_wr_stb <= 1'b0;
    bus_rst    <= 1'b1;
    repeat (5) begin
      @(posedge bus_clk);
      gps_pps <= $random(seed);
    end
    bus_rst <= 1'b0;

    // Button holds, length 1 is a glitch
    hold_button(1'b1, 20);
    repeat (16) begin
      hold_button(1'b0, 1 + ($unsigned($random(seed)) % 16));
      hold_button(1'b1, 1 + ($unsigned($random(seed)) % 16));
    end
    hold_button(1'b1, 4);
    hold_button(1'b0, 1);
    hold_button(1'b1, 4);
    hold_button(1'b0, 6);
    hold_button(1'b1, 1);
    hold_button(1'b0, 4);
    hold_button(1'b1, 12);

    $display("all tests passed");
    $finish;
  end

endmodule
